// ==== hdl/vbuff_settings.svh ====
/* Vector store buffer sizing
   Lane count, vector length and bus widths for the whole buffer */
`ifndef VBUFF_SETTINGS_SVH
`define VBUFF_SETTINGS_SVH

////////////////////////////////////////
// Vector unit geometry
////////////////////////////////////////
`define VB_LANES        8     // Vector lanes feeding the buffer
`define VB_VLENB        64    // Vector register length in bytes
`define VB_MAX_L2_LMUL  3     // LMUL up to 8

////////////////////////////////////////
// Bus widths
////////////////////////////////////////
`define VB_DATA_W       32    // Lane word and AXI data
`define VB_ADDR_W       32

// Rows per lane RAM, sized for a full LMUL=8 group of 32-bit words
`define VB_BUFF_DEPTH   ((`VB_VLENB << `VB_MAX_L2_LMUL) / 4 / `VB_LANES)

`endif

// ==== hdl/vbuff_pkg.sv ====
/* Vector store buffer types
   Element width and store mode encodings, lane word and index types */
`default_nettype none
`include "vbuff_settings.svh"

package vbuff_pkg;

  // Element width, encoding 2'd3 is illegal
  typedef enum logic [1:0] {
    SEW_8  = 2'd0,
    SEW_16 = 2'd1,
    SEW_32 = 2'd2
  } sew_e;

  typedef enum logic {
    ST_UNIT    = 1'b0,
    ST_STRIDED = 1'b1
  } store_mode_e;

  typedef logic [`VB_DATA_W-1:0]   lane_word_t;   // Lane or buffer word
  typedef logic [`VB_DATA_W/8-1:0] byte_en_t;     // One bit per byte
  typedef logic [`VB_LANES-1:0]    lane_mask_t;   // One bit per lane

  // Bank row address
  typedef logic [$clog2(`VB_BUFF_DEPTH)-1:0] row_addr_t;

  // Element count or index, holds the count of a full SEW=8 LMUL=8 group
  typedef logic [$clog2(`VB_VLENB << `VB_MAX_L2_LMUL):0] elem_idx_t;

endpackage

`default_nettype wire

// ==== hdl/sbuff_ram_if.sv ====
/* Store buffer bank ports
   Byte-write port driven by the packer, read port driven by the read pipe */
`timescale 1ns/100ps
`default_nettype none
`include "vbuff_settings.svh"

////////////////////////////////////////
// Write port
////////////////////////////////////////
interface sbuff_wr_if;
  import vbuff_pkg::*;

  logic       we;                  // Write strobe
  row_addr_t  row;
  lane_mask_t lane_en;             // Lanes written this beat
  byte_en_t   byte_en;
  lane_word_t wdata [`VB_LANES];

  modport ctrl (
    output we, row, lane_en, byte_en, wdata
  );

  modport ram (
    input  we, row, lane_en, byte_en, wdata
  );
endinterface

////////////////////////////////////////
// Read port
////////////////////////////////////////
interface sbuff_rd_if;
  import vbuff_pkg::*;

  logic       ren;
  row_addr_t  row;
  lane_word_t rdata [`VB_LANES];   // Valid the cycle after ren

  modport ctrl (
    output ren, row,
    input  rdata
  );

  modport ram (
    input  ren, row,
    output rdata
  );
endinterface

`default_nettype wire

// ==== hdl/store_issue_ctrl.sv ====
/* Store issue control
   Holds the store configuration, counts issued elements and steps the AXI address */
`timescale 1ns/100ps
`default_nettype none
`include "vbuff_settings.svh"

module store_issue_ctrl (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   cfg_load_i,
  input  vbuff_pkg::sew_e        cfg_sew_i,
  input  logic [1:0]             cfg_l2_lmul_i,
  input  vbuff_pkg::store_mode_e cfg_mode_i,
  input  logic [`VB_ADDR_W-1:0]  cfg_base_addr_i,
  input  logic [`VB_ADDR_W-1:0]  cfg_stride_i,
  input  logic                   rd_en_i,
  output vbuff_pkg::sew_e        sew_o,
  output vbuff_pkg::elem_idx_t   beats_o,
  output logic                   issue_o,
  output vbuff_pkg::elem_idx_t   elem_idx_o,
  output logic [`VB_ADDR_W-1:0]  byte_addr_o,
  output logic                   rd_done_o,
  output logic [`VB_ADDR_W-1:0]  xfer_size_o
);
  import vbuff_pkg::*;

  localparam int ADDR_W = `VB_ADDR_W;

  sew_e              sew_q;
  logic [1:0]        l2_lmul_q;
  store_mode_e       mode_q;
  logic [ADDR_W-1:0] stride_q;
  logic [ADDR_W-1:0] addr_q;       // Running element address
  elem_idx_t         rd_cnt_q;
  elem_idx_t         vec_bytes;    // Bytes in the register group
  elem_idx_t         n_elems;
  logic [2:0]        elem_bytes;
  logic [ADDR_W-1:0] addr_step;

  // Configuration registers
  always_ff @(posedge clk) begin
    if (!rstn) begin
      sew_q     <= SEW_8;
      l2_lmul_q <= '0;
      mode_q    <= ST_UNIT;
      stride_q  <= '0;
    end else if (cfg_load_i) begin
      sew_q     <= cfg_sew_i;
      l2_lmul_q <= cfg_l2_lmul_i;
      mode_q    <= cfg_mode_i;
      stride_q  <= cfg_stride_i;
    end
  end

  // Element count and transfer size
  assign vec_bytes   = elem_idx_t'(`VB_VLENB) << l2_lmul_q;
  assign n_elems     = vec_bytes >> sew_q;
  assign elem_bytes  = 3'd1 << sew_q;
  assign beats_o     = n_elems >> $clog2(`VB_LANES);   // One element per lane per beat
  assign sew_o       = sew_q;
  assign xfer_size_o = (mode_q == ST_UNIT) ? ADDR_W'(vec_bytes) : ADDR_W'(elem_bytes);
  assign addr_step   = (mode_q == ST_STRIDED) ? stride_q : ADDR_W'(elem_bytes);

  assign issue_o     = rd_en_i && !rd_done_o;           // Reads past the end are dropped
  assign elem_idx_o  = rd_cnt_q;
  assign byte_addr_o = addr_q;

  ////////////////////////////////////////
  // Element counter and address accumulator
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      rd_cnt_q  <= '0;
      addr_q    <= '0;
      rd_done_o <= 1'b0;
    end else if (cfg_load_i) begin
      rd_cnt_q  <= '0;
      addr_q    <= cfg_base_addr_i;
      rd_done_o <= 1'b0;
    end else if (issue_o) begin
      rd_cnt_q <= rd_cnt_q + 1'b1;
      addr_q   <= addr_q + addr_step;
      if (rd_cnt_q == n_elems - 1'b1) begin
        rd_done_o <= 1'b1;                              // Last element accepted
      end
    end
  end

  a_sew_legal: assert property (@(posedge clk) disable iff (!rstn)
    cfg_load_i |-> cfg_sew_i inside {SEW_8, SEW_16, SEW_32})
    else $error("illegal SEW encoding on config load");

endmodule

`default_nettype wire

// ==== hdl/store_pack_ctrl.sv ====
/* Store packing control
   Packs narrow lane elements into buffer words and steps the written lane group */
`timescale 1ns/100ps
`default_nettype none
`include "vbuff_settings.svh"

module store_pack_ctrl (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  cfg_load_i,
  input  vbuff_pkg::sew_e       sew_i,
  input  vbuff_pkg::elem_idx_t  beats_i,
  input  logic                  lane_wen_i,
  input  vbuff_pkg::lane_word_t lane_data_i [`VB_LANES],
  output logic                  wr_done_o,
  sbuff_wr_if.ctrl              wr
);
  import vbuff_pkg::*;

  localparam int LANES = `VB_LANES;
  localparam int GW    = $clog2(LANES) + 1;

  logic               beat;
  logic [GW-1:0]      grp_size;       // Lanes filled per beat
  lane_mask_t         grp_mask;
  lane_mask_t         lane_en;
  lane_mask_t         lane_en_q;      // Zero until the first beat after config
  logic [2*LANES-1:0] lane_en_dbl;
  row_addr_t          row_q;
  elem_idx_t          beat_cnt_q;

  assign beat     = lane_wen_i && !wr_done_o;
  assign grp_size = GW'(2) << sew_i;   // 8 beats of s bytes fill 2*s words
  assign grp_mask = lane_mask_t'((1 << grp_size) - 1);
  assign lane_en  = (lane_en_q == '0) ? grp_mask : lane_en_q;

  // Rotate the group left by its own size
  assign lane_en_dbl = {lane_en, lane_en} >> (LANES - int'(grp_size));

  ////////////////////////////////////////
  // Lane group, row and beat counters
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn || cfg_load_i) begin
      lane_en_q  <= '0;
      row_q      <= '0;
      beat_cnt_q <= '0;
      wr_done_o  <= 1'b0;
    end else if (beat) begin
      lane_en_q  <= lane_en_dbl[LANES-1:0];
      beat_cnt_q <= beat_cnt_q + 1'b1;
      if (lane_en[LANES-1]) begin
        row_q <= row_q + 1'b1;           // Group wraps back to lane 0
      end
      if (beat_cnt_q == beats_i - 1'b1) begin
        wr_done_o <= 1'b1;
      end
    end
  end

  // Write port, the beat lands on the edge that samples it
  assign wr.we      = beat;
  assign wr.row     = row_q;
  assign wr.lane_en = lane_en;
  assign wr.byte_en = '1;              // Packed words always fill the row

  // Lane l takes the low s bytes of 4/s consecutive source lanes
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      case (sew_i)
        SEW_32: begin
          wr.wdata[l] = lane_data_i[l];
        end
        SEW_16: begin
          wr.wdata[l] = {lane_data_i[(2*l)%LANES + 1][15:0],
                         lane_data_i[(2*l)%LANES][15:0]};
        end
        default: begin
          wr.wdata[l] = {lane_data_i[(4*l)%LANES + 3][7:0],
                         lane_data_i[(4*l)%LANES + 2][7:0],
                         lane_data_i[(4*l)%LANES + 1][7:0],
                         lane_data_i[(4*l)%LANES][7:0]};
        end
      endcase
    end
  end

  // Rotated group must stay one aligned run of grp_size lanes
  a_lane_group: assert property (@(posedge clk) disable iff (!rstn)
    beat |-> ($countones(lane_en) == int'(grp_size)) &&
             (((lane_en + (lane_en & (~lane_en + 1'b1))) & lane_en) == '0))
    else $error("lane enable group not contiguous");

endmodule

`default_nettype wire

// ==== hdl/sbuff_bank.sv ====
/* Store buffer bank
   One dual-port byte-write RAM per lane with a registered read */
`timescale 1ns/100ps
`default_nettype none
`include "vbuff_settings.svh"

module sbuff_bank (
  input  logic    clk,
  sbuff_wr_if.ram wr,
  sbuff_rd_if.ram rd
);
  import vbuff_pkg::*;

  localparam int LANES  = `VB_LANES;
  localparam int DEPTH  = `VB_BUFF_DEPTH;
  localparam int NBYTES = $bits(byte_en_t);

  for (genvar l = 0; l < LANES; l++) begin : g_lane
    lane_word_t mem [DEPTH];
    lane_word_t rdata_q;

    // Byte-write port
    always_ff @(posedge clk) begin
      if (wr.we && wr.lane_en[l]) begin
        for (int b = 0; b < NBYTES; b++) begin
          if (wr.byte_en[b]) begin
            mem[wr.row][8*b +: 8] <= wr.wdata[l][8*b +: 8];
          end
        end
      end
    end

    // Read port, one cycle latency
    always_ff @(posedge clk) begin
      if (rd.ren) begin
        rdata_q <= mem[rd.row];
      end
    end

    assign rd.rdata[l] = rdata_q;
  end

endmodule

`default_nettype wire

// ==== hdl/store_read_pipe.sv ====
/* Store read pipeline
   Reads one element per issue and forms the aligned AXI beat two cycles later */
`timescale 1ns/100ps
`default_nettype none
`include "vbuff_settings.svh"

module store_read_pipe (
  input  logic                  clk,
  input  logic                  rstn,
  input  vbuff_pkg::sew_e       sew_i,
  input  logic                  issue_i,
  input  vbuff_pkg::elem_idx_t  elem_idx_i,
  input  logic [`VB_ADDR_W-1:0] byte_addr_i,
  output logic                  axi_valid_o,
  output logic [`VB_ADDR_W-1:0] axi_addr_o,
  output vbuff_pkg::lane_word_t axi_wdata_o,
  output vbuff_pkg::byte_en_t   axi_wstrb_o,
  sbuff_rd_if.ctrl              rd
);
  import vbuff_pkg::*;

  localparam int LANE_W = $clog2(`VB_LANES);
  localparam int ROW_W  = $bits(row_addr_t);
  localparam int DW     = `VB_DATA_W;
  localparam int AW     = `VB_ADDR_W;
  localparam int NB     = $bits(byte_en_t);

  elem_idx_t         stream_byte;   // Byte offset of the element in the buffer
  logic [LANE_W-1:0] lane_s0;
  logic [LANE_W-1:0] lane_s1;
  logic [1:0]        off_s0;
  logic [1:0]        off_s1;
  logic              valid_s1;
  logic [AW-1:0]     addr_s1;
  lane_word_t        word_shr;
  lane_word_t        elem;
  byte_en_t          strb;
  logic [2*DW-1:0]   elem_dbl;
  logic [2*NB-1:0]   strb_dbl;

  ////////////////////////////////////////
  // Stage 0 row and lane lookup
  ////////////////////////////////////////
  assign stream_byte = elem_idx_i << sew_i;
  assign off_s0      = stream_byte[1:0];
  assign lane_s0     = stream_byte[2 +: LANE_W];         // Word index mod lanes
  assign rd.ren      = issue_i;
  assign rd.row      = stream_byte[2+LANE_W +: ROW_W];   // Word index div lanes

  always_ff @(posedge clk) begin
    if (!rstn) begin
      valid_s1 <= 1'b0;
    end else begin
      valid_s1 <= issue_i;
    end
  end

  // Travels alongside the RAM read
  always_ff @(posedge clk) begin
    if (issue_i) begin
      lane_s1 <= lane_s0;
      off_s1  <= off_s0;
      addr_s1 <= byte_addr_i;
    end
  end

  ////////////////////////////////////////
  // Stage 1 extract and rotate
  ////////////////////////////////////////
  assign word_shr = rd.rdata[lane_s1] >> {off_s1, 3'b000};

  always_comb begin
    case (sew_i)
      SEW_8: begin
        elem = {{(DW-8){1'b0}}, word_shr[7:0]};
        strb = 4'b0001;
      end
      SEW_16: begin
        elem = {{(DW-16){1'b0}}, word_shr[15:0]};
        strb = 4'b0011;
      end
      default: begin
        elem = word_shr;
        strb = 4'b1111;
      end
    endcase
  end

  // Upper halves hold the left rotation by the address byte offset
  assign elem_dbl = {elem, elem} << {addr_s1[1:0], 3'b000};
  assign strb_dbl = {strb, strb} << addr_s1[1:0];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      axi_valid_o <= 1'b0;
    end else begin
      axi_valid_o <= valid_s1;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_s1) begin
      axi_addr_o  <= {addr_s1[AW-1:2], 2'b00};   // Word aligned
      axi_wdata_o <= elem_dbl[2*DW-1:DW];
      axi_wstrb_o <= strb_dbl[2*NB-1:NB];
    end
  end

  // Beat two cycles after issue, strobe rotated without losing bytes
  a_beat_latency: assert property (@(posedge clk) disable iff (!rstn)
    issue_i |-> ##2 (axi_valid_o && ($countones(axi_wstrb_o) == (1 << sew_i))))
    else $error("AXI beat missing or strobe width wrong two cycles after issue");

endmodule

`default_nettype wire

// ==== hdl/store_buff_array.sv ====
/* Vector store buffer
   Packs lane writes into a byte-write bank and replays them as AXI write beats */
`timescale 1ns/100ps
`default_nettype none
`include "vbuff_settings.svh"

module store_buff_array (
  input  logic                            clk,
  input  logic                            rstn,
  // Configuration
  input  logic                            cfg_load_i,
  input  vbuff_pkg::sew_e                 cfg_sew_i,
  input  logic [1:0]                      cfg_l2_lmul_i,
  input  vbuff_pkg::store_mode_e          cfg_mode_i,
  input  logic [`VB_ADDR_W-1:0]           cfg_base_addr_i,
  input  logic [`VB_ADDR_W-1:0]           cfg_stride_i,
  // Vector lanes
  input  logic                            lane_wen_i,
  input  logic [`VB_LANES*`VB_DATA_W-1:0] lane_data_i,
  // Read side
  input  logic                            rd_en_i,
  output logic                            wr_done_o,
  output logic                            rd_done_o,
  output logic [`VB_ADDR_W-1:0]           xfer_size_o,
  // AXI write beat
  output logic                            axi_valid_o,
  output logic [`VB_ADDR_W-1:0]           axi_addr_o,
  output logic [`VB_DATA_W-1:0]           axi_wdata_o,
  output logic [3:0]                      axi_wstrb_o
);
  import vbuff_pkg::*;

  localparam int LANES = `VB_LANES;
  localparam int DW    = `VB_DATA_W;

  sew_e                  sew;
  elem_idx_t             beats;
  elem_idx_t             elem_idx;
  logic                  issue;
  logic [`VB_ADDR_W-1:0] byte_addr;
  lane_word_t            lane_data [LANES];

  // Lane 0 sits in the low word
  for (genvar l = 0; l < LANES; l++) begin : g_unflat
    assign lane_data[l] = lane_data_i[l*DW +: DW];
  end

  sbuff_wr_if u_wr_if ();
  sbuff_rd_if u_rd_if ();

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////
  store_issue_ctrl u_store_issue_ctrl (
    .clk             (clk),
    .rstn            (rstn),
    .cfg_load_i      (cfg_load_i),
    .cfg_sew_i       (cfg_sew_i),
    .cfg_l2_lmul_i   (cfg_l2_lmul_i),
    .cfg_mode_i      (cfg_mode_i),
    .cfg_base_addr_i (cfg_base_addr_i),
    .cfg_stride_i    (cfg_stride_i),
    .rd_en_i         (rd_en_i),
    .sew_o           (sew),
    .beats_o         (beats),
    .issue_o         (issue),
    .elem_idx_o      (elem_idx),
    .byte_addr_o     (byte_addr),
    .rd_done_o       (rd_done_o),
    .xfer_size_o     (xfer_size_o)
  );

  store_pack_ctrl u_store_pack_ctrl (
    .clk         (clk),
    .rstn        (rstn),
    .cfg_load_i  (cfg_load_i),
    .sew_i       (sew),
    .beats_i     (beats),
    .lane_wen_i  (lane_wen_i),
    .lane_data_i (lane_data),
    .wr_done_o   (wr_done_o),
    .wr          (u_wr_if)
  );

  ////////////////////////////////////////
  // Buffer and read path
  ////////////////////////////////////////
  sbuff_bank u_sbuff_bank (
    .clk (clk),
    .wr  (u_wr_if),
    .rd  (u_rd_if)
  );

  store_read_pipe u_store_read_pipe (
    .clk         (clk),
    .rstn        (rstn),
    .sew_i       (sew),
    .issue_i     (issue),
    .elem_idx_i  (elem_idx),
    .byte_addr_i (byte_addr),
    .axi_valid_o (axi_valid_o),
    .axi_addr_o  (axi_addr_o),
    .axi_wdata_o (axi_wdata_o),
    .axi_wstrb_o (axi_wstrb_o),
    .rd          (u_rd_if)
  );

endmodule

`default_nettype wire

// ==== tb/tb_store_buff_array.sv ====
/* Vector store buffer testbench
   Seeded random vectors checked against a byte-stream model of the buffer */
`timescale 1ns/100ps
`default_nettype none
`include "vbuff_settings.svh"

module tb_store_buff_array;
  import vbuff_pkg::*;

  localparam int LANES     = `VB_LANES;
  localparam int DW        = `VB_DATA_W;
  localparam int AW        = `VB_ADDR_W;
  localparam int MAX_BYTES = `VB_VLENB << `VB_MAX_L2_LMUL;
  localparam int NUM_RUNS  = 10;
  localparam int RUN_LEN   = MAX_BYTES + MAX_BYTES / LANES;   // Worst case reads plus writes
  localparam int WATCHDOG_CYCLES = NUM_RUNS * RUN_LEN * 20;

  logic                clk;
  logic                rstn;
  logic                cfg_load_i;
  sew_e                cfg_sew_i;
  logic [1:0]          cfg_l2_lmul_i;
  store_mode_e         cfg_mode_i;
  logic [AW-1:0]       cfg_base_addr_i;
  logic [AW-1:0]       cfg_stride_i;
  logic                lane_wen_i;
  logic [LANES*DW-1:0] lane_data_i;
  logic                rd_en_i;
  logic                wr_done_o;
  logic                rd_done_o;
  logic [AW-1:0]       xfer_size_o;
  logic                axi_valid_o;
  logic [AW-1:0]       axi_addr_o;
  logic [DW-1:0]       axi_wdata_o;
  logic [3:0]          axi_wstrb_o;

  logic [7:0]    stream [MAX_BYTES];   // Vector bytes in element order
  int            cyc;
  int            n_checks;
  int            n_errors;
  int            n_tests;
  int            exp_due [$];          // Cycle at which each beat must show
  logic [AW-1:0] exp_addr [$];
  logic [DW-1:0] exp_data [$];
  logic [3:0]    exp_strb [$];

  always #5 clk = ~clk;

  store_buff_array u_store_buff_array (
    .clk             (clk),
    .rstn            (rstn),
    .cfg_load_i      (cfg_load_i),
    .cfg_sew_i       (cfg_sew_i),
    .cfg_l2_lmul_i   (cfg_l2_lmul_i),
    .cfg_mode_i      (cfg_mode_i),
    .cfg_base_addr_i (cfg_base_addr_i),
    .cfg_stride_i    (cfg_stride_i),
    .lane_wen_i      (lane_wen_i),
    .lane_data_i     (lane_data_i),
    .rd_en_i         (rd_en_i),
    .wr_done_o       (wr_done_o),
    .rd_done_o       (rd_done_o),
    .xfer_size_o     (xfer_size_o),
    .axi_valid_o     (axi_valid_o),
    .axi_addr_o      (axi_addr_o),
    .axi_wdata_o     (axi_wdata_o),
    .axi_wstrb_o     (axi_wstrb_o)
  );

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Fail %s: got 0x%h, expected 0x%h at cycle %0d", name, got, exp, cyc);
    end
  endtask

  ////////////////////////////////////////
  // Model
  ////////////////////////////////////////
  // Element e gathered from the byte stream and zero extended
  function automatic logic [31:0] elem_value(input int e, input int s);
    logic [31:0] v;
    v = '0;
    for (int j = 0; j < s; j++) begin
      v[8*j +: 8] = stream[e*s + j];
    end
    return v;
  endfunction

  // Byte j lands on byte lane (j + sh) mod 4
  function automatic logic [31:0] rot_bytes(input logic [31:0] v, input int sh);
    logic [31:0] r;
    r = '0;
    for (int j = 0; j < 4; j++) begin
      r[8*((j + sh) % 4) +: 8] = v[8*j +: 8];
    end
    return r;
  endfunction

  function automatic logic [3:0] rot_strb(input int s, input int sh);
    logic [3:0] r;
    r = '0;
    for (int j = 0; j < s; j++) begin
      r[(j + sh) % 4] = 1'b1;
    end
    return r;
  endfunction

  task automatic fill_lanes();
    for (int k = 0; k < LANES; k++) begin
      lane_data_i[k*DW +: DW] = $urandom;
    end
  endtask

  // Wait for the falling edge and score whatever AXI beat is due this cycle
  task automatic tick();
    logic due;
    @(negedge clk);
    cyc++;
    due = (exp_due.size() > 0) && (exp_due[0] == cyc);
    check("axi_valid_o", 32'(axi_valid_o), 32'(due));
    if (due) begin
      if (axi_valid_o) begin
        check("axi_addr_o", axi_addr_o, exp_addr[0]);
        check("axi_wdata_o", axi_wdata_o, exp_data[0]);
        check("axi_wstrb_o", 32'(axi_wstrb_o), 32'(exp_strb[0]));
      end
      void'(exp_due.pop_front());
      void'(exp_addr.pop_front());
      void'(exp_data.pop_front());
      void'(exp_strb.pop_front());
    end
  endtask

  ////////////////////////////////////////
  // Configure, write and read back one vector
  ////////////////////////////////////////
  task automatic run_vector(input sew_e sew, input logic [1:0] l2, input store_mode_e mode,
                            input logic [AW-1:0] base, input logic [AW-1:0] stride,
                            input bit gaps, input bit extra);
    int            s;
    int            n;
    int            beats;
    int            wait_cnt;
    logic [31:0]   word;
    logic [AW-1:0] step;
    logic [AW-1:0] addr;
    s     = 1 << int'(sew);
    n     = (`VB_VLENB << int'(l2)) / s;
    beats = n / LANES;
    step  = (mode == ST_UNIT) ? AW'(s) : stride;
    cfg_sew_i       = sew;
    cfg_l2_lmul_i   = l2;
    cfg_mode_i      = mode;
    cfg_base_addr_i = base;
    cfg_stride_i    = stride;
    cfg_load_i      = 1'b1;
    tick();
    cfg_load_i = 1'b0;
    check("wr_done_o", 32'(wr_done_o), 32'h0);
    check("rd_done_o", 32'(rd_done_o), 32'h0);
    check("xfer_size_o", xfer_size_o, (mode == ST_UNIT) ? 32'(n * s) : 32'(s));

    for (int b = 0; b < beats; b++) begin
      while (gaps && ($urandom_range(3, 0) == 0)) begin
        fill_lanes();                       // Junk on the lanes while idle
        tick();
      end
      fill_lanes();
      for (int k = 0; k < LANES; k++) begin
        word = lane_data_i[k*DW +: DW];
        for (int j = 0; j < s; j++) begin
          stream[(b*LANES + k)*s + j] = word[8*j +: 8];
        end
      end
      lane_wen_i = 1'b1;
      tick();
      lane_wen_i = 1'b0;
      check("wr_done_o", 32'(wr_done_o), 32'(b == beats - 1));
    end
    if (extra) begin
      lane_wen_i = 1'b1;
      repeat (3) begin
        fill_lanes();                       // Must not reach the bank
        tick();
        check("wr_done_o", 32'(wr_done_o), 32'h1);
      end
      lane_wen_i = 1'b0;
    end

    for (int e = 0; e < n; e++) begin
      while (gaps && ($urandom_range(3, 0) == 0)) begin
        tick();
      end
      addr = base + AW'(e) * step;
      exp_due.push_back(cyc + 2);
      exp_addr.push_back({addr[AW-1:2], 2'b00});
      exp_data.push_back(rot_bytes(elem_value(e, s), int'(addr[1:0])));
      exp_strb.push_back(rot_strb(s, int'(addr[1:0])));
      rd_en_i = 1'b1;
      tick();
      rd_en_i = 1'b0;
      check("rd_done_o", 32'(rd_done_o), 32'(e == n - 1));
    end
    if (extra) begin
      rd_en_i = 1'b1;
      repeat (3) begin
        tick();                             // No beat may follow these
        check("rd_done_o", 32'(rd_done_o), 32'h1);
      end
      rd_en_i = 1'b0;
    end

    wait_cnt = 0;
    while ((exp_due.size() > 0) && (wait_cnt < 8)) begin
      tick();
      wait_cnt++;
    end
    if (exp_due.size() > 0) begin
      n_errors++;
      $display("AXI beats still outstanding well after the read phase ended");
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    n_tests++;
    if (n_errors == errs_before) begin
      $display("test %0d %s: ok", n_tests, name);
    end else begin
      $display("test %0d %s: %0d errors", n_tests, name, n_errors - errs_before);
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial begin
    int            errs;
    logic [AW-1:0] base;
    void'($urandom(32'hf7cd_c032));
    clk             = 1'b0;
    rstn            = 1'b0;
    cfg_load_i      = 1'b0;
    cfg_sew_i       = SEW_8;
    cfg_l2_lmul_i   = 2'd0;
    cfg_mode_i      = ST_UNIT;
    cfg_base_addr_i = '0;
    cfg_stride_i    = '0;
    lane_wen_i      = 1'b0;
    lane_data_i     = '0;
    rd_en_i         = 1'b0;
    repeat (8) tick();
    rstn = 1'b1;

    errs = n_errors;
    repeat (3) begin
      check("wr_done_o", 32'(wr_done_o), 32'h0);
      check("rd_done_o", 32'(rd_done_o), 32'h0);
      tick();
    end
    end_test("reset", errs);

    errs = n_errors;
    repeat (2) run_vector(SEW_32, 2'($urandom_range(3, 0)), ST_UNIT, $urandom, '0, 1'b1, 1'b0);
    end_test("sew32_unit", errs);

    errs = n_errors;
    for (int i = 0; i < 2; i++) begin
      base      = $urandom;
      base[1:0] = 2'($urandom_range(3, 1));     // Force an unaligned base
      run_vector(sew_e'(i), 2'($urandom_range(3, 0)), ST_UNIT, base, '0, 1'b1, 1'b0);
    end
    end_test("narrow_unit", errs);

    errs = n_errors;
    for (int i = 0; i < 3; i++) begin
      run_vector(sew_e'(i), 2'($urandom_range(3, 0)), ST_STRIDED, $urandom, $urandom,
                 1'b1, 1'b0);
    end
    end_test("strided", errs);

    // Full LMUL=8 group fills every row, so a stray write would land on row 0
    errs = n_errors;
    run_vector(sew_e'($urandom_range(2, 0)), 2'd3, ST_UNIT, $urandom, '0, 1'b1, 1'b1);
    end_test("done_flags", errs);

    errs = n_errors;
    run_vector(SEW_8, 2'($urandom_range(3, 0)), ST_UNIT, $urandom, '0, 1'b0, 1'b0);
    run_vector(SEW_16, 2'($urandom_range(3, 0)), ST_STRIDED, $urandom, $urandom, 1'b0, 1'b0);
    end_test("back_to_back", errs);

    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Hang guard sized from the worst case run length
  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hdl
hdl/vbuff_pkg.sv
hdl/sbuff_ram_if.sv
hdl/store_issue_ctrl.sv
hdl/store_pack_ctrl.sv
hdl/sbuff_bank.sv
hdl/store_read_pipe.sv
hdl/store_buff_array.sv
tb/tb_store_buff_array.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the vector store buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module tb_store_buff_array -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_tb 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "TESTBENCH PASSED"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
